// File: rtl/video_timing_pkg.sv
// Shared definitions for the 640x480 at 60 Hz raster timing generator
// Holds the mode constants, the derived counter limits and the common types
package video_timing_pkg;

  // ===================================================================
  // Types
  // ===================================================================

  // Horizontal or vertical position, wide enough for any counter limit
  typedef logic [11:0] coord_t;

  // Input colour with one nibble per channel, sampled every pixel clock
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  // Output colour with one byte per channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // Horizontal state handed to the pixel stage
  // The edge flag marks the first and the last active pixel of a line
  typedef struct packed {
    logic act;
    logic edge_flag;
  } h_state_t;

  // Vertical state handed to the pixel stage
  // The edge flag stays up for the whole first and last active line
  typedef struct packed {
    logic act;
    logic edge_flag;
  } v_state_t;

  // ===================================================================
  // Mode constants for 640x480 at 60 Hz, 25.175 MHz pixel clock
  // ===================================================================

  localparam coord_t H_DISPLAY = 12'd640;
  localparam coord_t H_FP      = 12'd16;
  localparam coord_t H_PULSE   = 12'd96;
  localparam coord_t H_BP      = 12'd48;

  localparam coord_t V_DISPLAY = 12'd480;
  localparam coord_t V_FP      = 12'd10;
  localparam coord_t V_PULSE   = 12'd2;
  localparam coord_t V_BP      = 12'd33;

  // Clocks between the horizontal active flag and data enable at the pins
  localparam coord_t H_PIPE    = 12'd2;

  // ===================================================================
  // Derived counter limits
  // ===================================================================

  // Last horizontal count of a line, 799
  localparam coord_t H_TOTAL = H_DISPLAY + H_FP + H_PULSE + H_BP - 12'd1;
  // Last count with hsync low, 95
  localparam coord_t H_SYNC  = H_PULSE - 12'd1;
  // Count at which the active flag is set, pulled early to cover the pipeline
  localparam coord_t H_START = H_PULSE + H_BP - 12'd1 - H_PIPE;
  // Count at which the active flag is cleared, 781
  localparam coord_t H_END   = H_START + H_DISPLAY;

  // Last line of a frame, 524
  localparam coord_t V_TOTAL = V_DISPLAY + V_FP + V_PULSE + V_BP - 12'd1;
  // Last line of the vsync pulse counted from zero, 1
  localparam coord_t V_SYNC  = V_PULSE - 12'd1;
  // Line at whose end the vertical active flag is set, 34
  localparam coord_t V_START = V_PULSE + V_BP - 12'd1;
  // Line at whose end the vertical active flag is cleared, 514
  localparam coord_t V_END   = V_START + V_DISPLAY;

endpackage

// File: rtl/line_timer.sv
// Horizontal timer for the raster generator
// Counts pixels in a line and makes hsync, the active window and the line-end strobe
`timescale 1ns/100ps

module line_timer import video_timing_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  output logic     hsync,
  output h_state_t h_state,
  output logic     line_end
);

  // ===================================================================
  // Counter and decodes
  // ===================================================================

  coord_t h_count;
  logic   h_act;
  // Active flag one clock late, used to find its rising edge
  logic   h_act_d;
  logic   sync_done;
  logic   act_start;
  logic   act_last;

  // Strobe on the final pixel of every line
  assign line_end  = (h_count == H_TOTAL);

  // High from the end of the sync pulse onwards
  assign sync_done = (h_count >= H_SYNC);
  assign act_start = (h_count == H_START);

  // The count sits on H_END during the last active pixel, as the flag
  // only drops on the following clock
  assign act_last  = (h_count == H_END);

  // ===================================================================
  // Registers
  // ===================================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      h_count <= '0;
      hsync   <= 1'b1;
      h_act   <= 1'b0;
      h_act_d <= 1'b0;
    end
    else
    begin
      h_act_d <= h_act;

      if (line_end)
        h_count <= '0;
      else
        h_count <= h_count + 12'd1;

      // Low while the count runs 0 to H_SYNC, registered so it has no glitches
      hsync <= sync_done && !line_end;

      if (act_start)
        h_act <= 1'b1;
      else if (act_last)
        h_act <= 1'b0;
    end
  end

  // First active pixel shows as the new flag against the delayed one
  assign h_state = '{act: h_act, edge_flag: (h_act && !h_act_d) || act_last};

  // ===================================================================
  // Checks
  // ===================================================================

  // The sync pulse must end within its nominal width
  a_hsync_width: assert property (
    @(posedge clk) disable iff (!reset_n)
    $fell(hsync) |-> ##[1:H_PULSE] hsync
  ) else $error("hsync held low longer than the pulse width");

endmodule

// File: rtl/frame_timer.sv
// Vertical timer for the raster generator
// Counts lines on the line-end strobe and makes vsync and the vertical window
`timescale 1ns/100ps

module frame_timer import video_timing_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     line_end,
  output logic     vsync,
  output v_state_t v_state
);

  // ===================================================================
  // Counter and decodes
  // ===================================================================

  coord_t v_count;
  logic   v_act;
  // Vertical active flag from the previous line
  logic   v_act_d;
  logic   frame_end;
  logic   sync_done;
  logic   act_start;
  logic   act_last;

  // Last line of the frame
  assign frame_end = (v_count == V_TOTAL);

  // From line V_SYNC onwards the pulse is over at the next line boundary
  assign sync_done = (v_count >= V_SYNC);
  assign act_start = (v_count == V_START);

  // Whole line V_END is still active, the flag drops at its end
  assign act_last  = (v_count == V_END);

  // ===================================================================
  // Registers
  // ===================================================================

  // Everything here moves only on the final pixel of a line, so vertical
  // changes land on the same clock as the wrap of the horizontal count
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      v_count <= '0;
      vsync   <= 1'b1;
      v_act   <= 1'b0;
      v_act_d <= 1'b0;
    end
    else if (line_end)
    begin
      v_act_d <= v_act;

      if (frame_end)
        v_count <= '0;
      else
        v_count <= v_count + 12'd1;

      // Low during lines 0 and 1 of each frame
      vsync <= sync_done && !frame_end;

      if (act_start)
        v_act <= 1'b1;
      else if (act_last)
        v_act <= 1'b0;
    end
  end

  // ===================================================================
  // Outputs
  // ===================================================================

  // The first active line is the only one where the flag is new against
  // the previous line; the last one comes from the count match
  assign v_state = '{act: v_act, edge_flag: (v_act && !v_act_d) || act_last};

  // ===================================================================
  // Checks
  // ===================================================================

  // Line count may only move right after a line-end strobe, and that
  // strobe lasts a single clock so one line never counts twice
  a_count_on_line_end: assert property (
    @(posedge clk) disable iff (!reset_n)
    $changed(v_count) |-> $past(line_end) && !line_end
  ) else $error("line count changed without a single-cycle line-end strobe");

endmodule

// File: rtl/pixel_mux.sv
// Pixel stage of the raster generator
// Delays the window into data enable, draws the border and widens the colour
`timescale 1ns/100ps

module pixel_mux import video_timing_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  h_state_t h_state,
  input  v_state_t v_state,
  input  rgb444_t  pixel_in,
  output logic     de,
  output rgb888_t  pixel_out
);

  // ===================================================================
  // Colour expansion
  // ===================================================================

  // First stage of data enable
  logic    de_pre;
  // Set one clock after any edge flag, lines up with de_pre
  logic    border;
  rgb888_t expanded;

  // Repeating each nibble maps 4'hF to 8'hFF and 4'h0 to 8'h00 exactly
  assign expanded.r = {pixel_in.r, pixel_in.r};
  assign expanded.g = {pixel_in.g, pixel_in.g};
  assign expanded.b = {pixel_in.b, pixel_in.b};

  // ===================================================================
  // Pipeline
  // ===================================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      de_pre    <= 1'b0;
      de        <= 1'b0;
      border    <= 1'b0;
      pixel_out <= '0;
    end
    else
    begin
      // Two clocks from the window flags to the pin
      de_pre <= h_state.act && v_state.act;
      de     <= de_pre;

      // Outside the window this also fires, de masks it there
      border <= h_state.edge_flag || v_state.edge_flag;

      // Colour takes one clock, the border decision two, both meet with de
      if (border)
        pixel_out <= '1;
      else
        pixel_out <= expanded;
    end
  end

  // ===================================================================
  // Checks
  // ===================================================================

  // Every de pulse opens on a border pixel, so the timers and this stage
  // must agree on the alignment of the edge flags
  a_de_starts_on_border: assert property (
    @(posedge clk) disable iff (!reset_n)
    $rose(de) |-> $past(border)
  ) else $error("data enable rose without a border pixel");

endmodule

// File: rtl/video_timing_top.sv
// Top level of the 640x480 at 60 Hz raster timing generator
// Connects the line timer, the frame timer and the pixel stage
`timescale 1ns/100ps

module video_timing_top import video_timing_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  rgb444_t pixel_in,
  output logic    hsync,
  output logic    vsync,
  output logic    de,
  output rgb888_t pixel_out
);

  // ===================================================================
  // Internal nets
  // ===================================================================

  h_state_t h_state;
  v_state_t v_state;
  // One clock per line, advances the frame timer
  logic     line_end;

  // Horizontal timing, also the source of hsync
  line_timer u_line_timer (
    .clk      (clk),
    .reset_n  (reset_n),
    .hsync    (hsync),
    .h_state  (h_state),
    .line_end (line_end)
  );

  // Vertical timing, steps once per line
  frame_timer u_frame_timer (
    .clk      (clk),
    .reset_n  (reset_n),
    .line_end (line_end),
    .vsync    (vsync),
    .v_state  (v_state)
  );

  // Data enable and colour, two clocks behind the timers
  pixel_mux u_pixel_mux (
    .clk       (clk),
    .reset_n   (reset_n),
    .h_state   (h_state),
    .v_state   (v_state),
    .pixel_in  (pixel_in),
    .de        (de),
    .pixel_out (pixel_out)
  );

endmodule

// File: dv/tb_video_timing.sv
// Testbench for the 640x480 at 60 Hz raster timing generator
// Drives random colours and checks every output cycle against a timing model
`timescale 1ns/100ps

module tb_video_timing import video_timing_pkg::*;
();

  // ======================================================================
  // Timing of the mode, taken from the timing rules
  // ======================================================================

  localparam int CLK_PERIOD      = 4;
  localparam int LINE_CYCLES     = 800;
  localparam int FRAME_LINES     = 525;
  localparam int FRAME_CYCLES    = LINE_CYCLES * FRAME_LINES;
  localparam int H_SYNC_LAST     = 95;
  localparam int H_ACT_FIRST     = 142;
  localparam int H_ACT_LAST      = 781;
  localparam int V_SYNC_LAST     = 1;
  localparam int V_ACT_FIRST     = 35;
  localparam int V_ACT_LAST      = 514;
  localparam int HSYNC_LEN       = 96;
  localparam int VSYNC_LEN       = 2 * LINE_CYCLES;
  localparam int DE_LEN          = 640;
  localparam int DE_LINES        = 480;
  localparam int RUN_CYCLES      = 2 * FRAME_CYCLES + 100;
  localparam int WATCHDOG_CYCLES = FRAME_CYCLES * 5 / 2;

  logic    clk = 1'b0;
  logic    reset_n;
  rgb444_t pixel_in;
  logic    hsync;
  logic    vsync;
  logic    de;
  rgb888_t pixel_out;

  // Model state, always the state right after the last rising edge
  int      h_m;
  int      v_m;
  logic    hsync_m;
  logic    vsync_m;
  logic    de_pre_m;
  logic    de_m;
  logic    border_m;
  rgb888_t pix_m;
  // Colour on pixel_in now, which the next rising edge samples
  rgb444_t pixel_sent;

  // Pulse monitors, with the output values of the cycle before
  int      hs_run;
  int      hs_period;
  int      hs_falls;
  int      vs_run;
  int      vs_period;
  int      vs_falls;
  int      de_run;
  int      de_pulses;
  logic    hsync_q;
  logic    vsync_q;
  logic    de_q;
  rgb888_t pixel_out_q;

  int      errors;
  int      checks;

  video_timing_top uut (
    .clk       (clk),
    .reset_n   (reset_n),
    .pixel_in  (pixel_in),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .pixel_out (pixel_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ======================================================================
  // Helpers
  // ======================================================================

  // Multiplying a nibble by 17 puts a copy of it in both halves of the byte
  function automatic rgb888_t widen_colour(input rgb444_t c);
    rgb888_t w;
    w.r = 8'h11 * c.r;
    w.g = 8'h11 * c.g;
    w.b = 8'h11 * c.b;
    return w;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
  endtask

  task automatic drive_pixel();
    logic [31:0] r;
    r = $urandom;
    pixel_sent = r[11:0];
    pixel_in   = pixel_sent;
  endtask

  // One rising edge of the model
  // The window and border come from the counts before the edge, data enable
  // leaves two clocks later and the border one clock later with the colour
  task automatic step_model();
    logic a;
    logic e;
    a = (h_m >= H_ACT_FIRST) && (h_m <= H_ACT_LAST) &&
        (v_m >= V_ACT_FIRST) && (v_m <= V_ACT_LAST);
    e = (h_m == H_ACT_FIRST) || (h_m == H_ACT_LAST) ||
        (v_m == V_ACT_FIRST) || (v_m == V_ACT_LAST);
    if (border_m)
      pix_m = '1;
    else
      pix_m = widen_colour(pixel_sent);
    de_m     = de_pre_m;
    de_pre_m = a;
    border_m = e;
    if (h_m == LINE_CYCLES - 1)
    begin
      h_m     = 0;
      v_m     = (v_m == FRAME_LINES - 1) ? 0 : v_m + 1;
      vsync_m = (v_m > V_SYNC_LAST);
    end
    else
      h_m++;
    hsync_m = (h_m > H_SYNC_LAST);
  endtask

  task automatic check_outputs();
    checks += 4;
    if (hsync !== hsync_m)
      report_mismatch("hsync", hsync, hsync_m);
    if (vsync !== vsync_m)
      report_mismatch("vsync", vsync, vsync_m);
    if (de !== de_m)
      report_mismatch("de", de, de_m);
    if (pixel_out !== pix_m)
      report_mismatch("pixel_out", pixel_out, pix_m);
  endtask

  // Pulse widths, periods and border pixels, seen only from the outputs
  // The first sync pulses after reset are short, so their runs are skipped
  task automatic watch_pulses();
    hs_period++;
    vs_period++;
    if (hsync_q && !hsync)
    begin
      if (hs_falls > 1)
      begin
        checks++;
        if (hs_period != LINE_CYCLES)
          report_mismatch("hsync period", hs_period, LINE_CYCLES);
      end
      hs_falls++;
      hs_period = 0;
      hs_run    = 0;
    end
    if (!hsync)
      hs_run++;
    if (!hsync_q && hsync && hs_falls > 1)
    begin
      checks++;
      if (hs_run != HSYNC_LEN)
        report_mismatch("hsync low run", hs_run, HSYNC_LEN);
    end

    // De pulses are counted per frame, from one vsync fall to the next
    if (vsync_q && !vsync)
    begin
      if (vs_falls > 0)
      begin
        checks++;
        if (de_pulses != DE_LINES)
          report_mismatch("de pulses per frame", de_pulses, DE_LINES);
      end
      if (vs_falls > 1)
      begin
        checks++;
        if (vs_period != FRAME_CYCLES)
          report_mismatch("vsync period", vs_period, FRAME_CYCLES);
      end
      vs_falls++;
      vs_period = 0;
      vs_run    = 0;
      de_pulses = 0;
    end
    if (!vsync)
      vs_run++;
    if (!vsync_q && vsync && vs_falls > 1)
    begin
      checks++;
      if (vs_run != VSYNC_LEN)
        report_mismatch("vsync low run", vs_run, VSYNC_LEN);
    end

    if (!de_q && de)
    begin
      de_run = 0;
      de_pulses++;
    end
    if (de)
    begin
      de_run++;
      // First pixel of a pulse, or any pixel of the top or bottom line
      if (!de_q || de_pulses == 1 || de_pulses == DE_LINES)
      begin
        checks++;
        if (pixel_out !== 24'hffffff)
          report_mismatch("pixel_out border", pixel_out, 24'hffffff);
      end
    end
    if (de_q && !de)
    begin
      checks += 2;
      if (de_run != DE_LEN)
        report_mismatch("de pulse length", de_run, DE_LEN);
      if (pixel_out_q !== 24'hffffff)
        report_mismatch("pixel_out last border", pixel_out_q, 24'hffffff);
    end

    hsync_q     = hsync;
    vsync_q     = vsync;
    de_q        = de;
    pixel_out_q = pixel_out;
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial
  begin
    errors      = 0;
    checks      = 0;
    reset_n     = 1'b0;
    pixel_in    = '0;
    pixel_sent  = '0;
    h_m         = 0;
    v_m         = 0;
    hsync_m     = 1'b1;
    vsync_m     = 1'b1;
    de_pre_m    = 1'b0;
    de_m        = 1'b0;
    border_m    = 1'b0;
    pix_m       = '0;
    hs_run      = 0;
    hs_period   = 0;
    hs_falls    = 0;
    vs_run      = 0;
    vs_period   = 0;
    vs_falls    = 0;
    de_run      = 0;
    de_pulses   = 0;
    hsync_q     = 1'b1;
    vsync_q     = 1'b1;
    de_q        = 1'b0;
    pixel_out_q = '0;
    void'($urandom(32'h25b5));

    repeat (3) @(posedge clk);
    @(negedge clk);

    // Reset levels, before the first counting edge
    checks += 4;
    if (hsync !== 1'b1)
      report_mismatch("hsync after reset", hsync, 1'b1);
    if (vsync !== 1'b1)
      report_mismatch("vsync after reset", vsync, 1'b1);
    if (de !== 1'b0)
      report_mismatch("de after reset", de, 1'b0);
    if (pixel_out !== '0)
      report_mismatch("pixel_out after reset", pixel_out, 24'h0);

    reset_n = 1'b1;
    drive_pixel();

    // Outputs are stable at the falling edge, then the next colour goes out
    repeat (RUN_CYCLES)
    begin
      @(negedge clk);
      step_model();
      check_outputs();
      watch_pulses();
      drive_pixel();
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Two and a half frames is well past the end of the normal run
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: video_timing.f
rtl/video_timing_pkg.sv
rtl/line_timer.sv
rtl/frame_timer.sv
rtl/pixel_mux.sv
rtl/video_timing_top.sv
dv/tb_video_timing.sv
